//--- src/gf_pkg.sv
`default_nettype none

package gf_pkg;

	// Width of one GF(2^4) element in standard basis.
	localparam int GF_M = 4;

	// x^4 + x + 1 with the x^4 term dropped.
	// A shift that carries out of the top bit folds back in as this pattern.
	localparam logic [GF_M-1:0] GF_POLY = 4'b0011;

	// Code length and number of evaluation points of the Chien search.
	localparam int GF_N = 15;

	// Positions run 0 to 14 and root counts 0 to 15, so four bits hold either.
	localparam int GF_POS_W = 4;
	localparam int GF_CNT_W = 4;

	// One field element, bit b is the coefficient of alpha^b.
	typedef logic [GF_M-1:0] gf_elem_t;

	// Index of an evaluation point alpha^i.
	typedef logic [GF_POS_W-1:0] gf_pos_t;

	// Number of locator roots found in one run.
	typedef logic [GF_CNT_W-1:0] gf_count_t;

endpackage

`default_nettype wire

//--- src/gf_const_mul.sv
`default_nettype none

module gf_const_mul #(
	parameter int K = 1
) (
	input  gf_pkg::gf_elem_t in,
	output gf_pkg::gf_elem_t out
);

	localparam int M = gf_pkg::GF_M;

	// Each basis element x^b is multiplied by alpha^K, one multiply-by-x step at a time.
	// The resulting column tells which output bits input bit b feeds.
	// The columns are then transposed into one input mask per output bit.
	function automatic logic [M*M-1:0] row_masks(input int k);
		logic [M*M-1:0] rows;
		logic [M-1:0] col;
		int steps;
		rows = '0;
		steps = k % gf_pkg::GF_N;
		for (int b = 0; b < M; b++) begin
			col = M'(1) << b;
			for (int s = 0; s < steps; s++) begin
				col = {col[M-2:0], 1'b0} ^ (col[M-1] ? gf_pkg::GF_POLY : '0);
			end
			for (int i = 0; i < M; i++) begin
				rows[i*M+b] = col[i];
			end
		end
		return rows;
	endfunction

	localparam logic [M*M-1:0] ROWS = row_masks(K);

	// A multiple of 15 gives identity masks, so the network reduces to wires.
	genvar i;
	for (i = 0; i < M; i++) begin : g_bit
		assign out[i] = ^(in & ROWS[i*M +: M]);
	end

endmodule

`default_nettype wire

//--- src/chien_bank.sv
`default_nettype none

module chien_bank #(
	parameter int T   = 3,
	parameter int ODD = 0
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    load,
	input  gf_pkg::gf_elem_t [T:0] sigma,
	output gf_pkg::gf_elem_t       term_sum
);

	// The even bank holds degrees 0, 2, 4 and so on, the odd bank 1, 3, 5 and so on.
	localparam int NT = (ODD != 0) ? (T + 1) / 2 : T / 2 + 1;

	gf_pkg::gf_elem_t terms [NT];

	genvar n;
	for (n = 0; n < NT; n++) begin : g_term
		localparam int J = 2 * n + ((ODD != 0) ? 1 : 0);

		gf_pkg::gf_elem_t term_q;
		gf_pkg::gf_elem_t term_next;

		// Each step advances the term of degree J from alpha^(i*J) to alpha^((i+1)*J).
		gf_const_mul #(
			.K(J)
		) u_mul (
			.in (term_q),
			.out(term_next)
		);

		always_ff @(posedge clk) begin
			if (reset) begin
				term_q <= '0;
			end else if (load) begin
				term_q <= sigma[J];
			end else begin
				term_q <= term_next;
			end
		end

		assign terms[n] = term_q;
	end

	// Field addition is XOR, so the bank sum is a plain XOR across the terms.
	always_comb begin
		term_sum = '0;
		for (int k = 0; k < NT; k++) begin
			term_sum = term_sum ^ terms[k];
		end
	end

endmodule

`default_nettype wire

//--- src/chien_combine.sv
`default_nettype none

module chien_combine (
	input  wire               clk,
	input  wire               reset,
	input  wire               load,
	input  gf_pkg::gf_elem_t  even_sum,
	input  gf_pkg::gf_elem_t  odd_sum,
	output logic              step_valid,
	output gf_pkg::gf_pos_t   position,
	output gf_pkg::gf_elem_t  eval_value,
	output gf_pkg::gf_elem_t  odd_value,
	output logic              root,
	output logic              done,
	output gf_pkg::gf_count_t root_count,
	output logic              busy
);

	localparam gf_pkg::gf_pos_t LAST_POS = gf_pkg::gf_pos_t'(gf_pkg::GF_N - 1);

	typedef enum logic {
		ST_IDLE,
		ST_SCAN
	} state_t;

	state_t state;
	gf_pkg::gf_pos_t scan_pos;
	gf_pkg::gf_elem_t eval_now;
	logic is_root;

	// The banks show sigma(alpha^scan_pos) split into its even and odd halves.
	assign eval_now = even_sum ^ odd_sum;
	assign is_root = (eval_now == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= ST_IDLE;
			scan_pos   <= '0;
			step_valid <= 1'b0;
			root       <= 1'b0;
			done       <= 1'b0;
			root_count <= '0;
			busy       <= 1'b0;
		end else if (load) begin
			// A load in the middle of a run drops the point in flight and starts over.
			state      <= ST_SCAN;
			scan_pos   <= '0;
			step_valid <= 1'b0;
			root       <= 1'b0;
			done       <= 1'b0;
			root_count <= '0;
			busy       <= 1'b1;
		end else begin
			case (state)
				ST_SCAN: begin
					step_valid <= 1'b1;
					root       <= is_root;
					root_count <= root_count + gf_pkg::gf_count_t'(is_root);
					scan_pos   <= scan_pos + gf_pkg::gf_pos_t'(1);
					if (scan_pos == LAST_POS) begin
						done  <= 1'b1;
						state <= ST_IDLE;
					end else begin
						done <= 1'b0;
					end
				end
				default: begin
					step_valid <= 1'b0;
					root       <= 1'b0;
					done       <= 1'b0;
					// busy stays up through the cycle that carries done.
					if (done) begin
						busy <= 1'b0;
					end
				end
			endcase
		end
	end

	// Point data is only meaningful while step_valid is high.
	always_ff @(posedge clk) begin
		if (state == ST_SCAN) begin
			position   <= scan_pos;
			eval_value <= eval_now;
			odd_value  <= odd_sum;
		end
	end

endmodule

`default_nettype wire

//--- src/chien_search.sv
`default_nettype none

module chien_search #(
	parameter int T = 3
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    load,
	input  gf_pkg::gf_elem_t [T:0] sigma,
	output logic                   step_valid,
	output gf_pkg::gf_pos_t        position,
	output gf_pkg::gf_elem_t       eval_value,
	output gf_pkg::gf_elem_t       odd_value,
	output logic                   root,
	output logic                   done,
	output gf_pkg::gf_count_t      root_count,
	output logic                   busy
);

	gf_pkg::gf_elem_t even_sum;
	gf_pkg::gf_elem_t odd_sum;

	chien_bank #(
		.T  (T),
		.ODD(0)
	) u_even_bank (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.sigma   (sigma),
		.term_sum(even_sum)
	);

	// The odd-degree sum also feeds the Forney stage through odd_value.
	chien_bank #(
		.T  (T),
		.ODD(1)
	) u_odd_bank (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.sigma   (sigma),
		.term_sum(odd_sum)
	);

	chien_combine u_combine (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.even_sum  (even_sum),
		.odd_sum   (odd_sum),
		.step_valid(step_valid),
		.position  (position),
		.eval_value(eval_value),
		.odd_value (odd_value),
		.root      (root),
		.done      (done),
		.root_count(root_count),
		.busy      (busy)
	);

endmodule

`default_nettype wire

//--- test/chien_search_tb.sv
`default_nettype none

module chien_search_tb;

	localparam int T = 3;
	localparam int N = 15;
	localparam int TIMEOUT = 50;

	logic clk;
	logic reset;
	logic load;
	logic [T:0][3:0] sigma;
	logic step_valid;
	logic [3:0] position;
	logic [3:0] eval_value;
	logic [3:0] odd_value;
	logic root;
	logic done;
	logic [3:0] root_count;
	logic busy;

	int errors;
	int tests_passed;
	int tests_failed;
	logic [31:0] rng_state;
	logic [N-1:0] seen_roots;

	chien_search #(
		.T(T)
	) UUT (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.sigma     (sigma),
		.step_valid(step_valid),
		.position  (position),
		.eval_value(eval_value),
		.odd_value (odd_value),
		.root      (root),
		.done      (done),
		.root_count(root_count),
		.busy      (busy)
	);

	always #20 clk = ~clk;

	// product in GF(2^4) by shift and add, reduced by x^4 + x + 1.
	function automatic logic [3:0] field_mul(input logic [3:0] a, input logic [3:0] b);
		logic [3:0] acc;
		logic [3:0] sh;
		acc = 4'h0;
		sh = a;
		for (int i = 0; i < 4; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			sh = sh[3] ? ({sh[2:0], 1'b0} ^ 4'h3) : {sh[2:0], 1'b0};
		end
		return acc;
	endfunction

	function automatic logic [3:0] alpha_pow(input int e);
		logic [3:0] r;
		r = 4'h1;
		for (int i = 0; i < e % N; i++) begin
			r = field_mul(r, 4'h2);
		end
		return r;
	endfunction

	// Horner evaluation of the whole locator.
	function automatic logic [3:0] locator_eval(input logic [T:0][3:0] s, input logic [3:0] x);
		logic [3:0] acc;
		acc = 4'h0;
		for (int j = T; j >= 0; j--) begin
			acc = field_mul(acc, x) ^ s[j];
		end
		return acc;
	endfunction

	function automatic logic [3:0] odd_terms(input logic [T:0][3:0] s, input logic [3:0] x);
		logic [3:0] acc;
		logic [3:0] xp;
		acc = 4'h0;
		xp = 4'h1;
		for (int j = 0; j <= T; j++) begin
			if (j % 2 == 1) begin
				acc = acc ^ field_mul(s[j], xp);
			end
			xp = field_mul(xp, x);
		end
		return acc;
	endfunction

	// multiplies the locator by (1 + alpha^p x) and keeps T+1 coefficients.
	function automatic logic [T:0][3:0] mul_factor(input logic [T:0][3:0] s, input int p);
		logic [T:0][3:0] r;
		logic [3:0] a;
		a = alpha_pow(p);
		r[0] = s[0];
		for (int j = 1; j <= T; j++) begin
			r[j] = s[j] ^ field_mul(a, s[j-1]);
		end
		return r;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] v;
		v = x;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	task automatic check_val(input string name, input logic [3:0] got, input logic [3:0] exp,
			input int step);
		assert (got === exp) else begin
			$display("Mismatch %s at step %0d: got 0x%h, expected 0x%h", name, step, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%s", msg);
			errors++;
		end
	endtask

	task automatic check_roots(input logic [N-1:0] mask);
		assert (seen_roots === mask) else begin
			$display("Mismatch root positions: got 0x%h, expected 0x%h", seen_roots, mask);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	// Loads the coefficients and checks up to `steps` points against the model.
	// A short run returns on the falling edge where the next point is shown.
	task automatic run_locator(input logic [T:0][3:0] coeffs, input int steps);
		int waited;
		int exp_count;
		logic [3:0] x;
		logic [3:0] ev;
		seen_roots = '0;
		exp_count = 0;
		sigma = coeffs;
		load = 1'b1;
		@(negedge clk);
		load = 1'b0;
		sigma = '0;
		check_val("busy", {3'b0, busy}, 4'h1, -1);
		check_val("step_valid", {3'b0, step_valid}, 4'h0, -1);
		check_val("root_count", root_count, 4'h0, -1);
		waited = 0;
		while (!step_valid && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!step_valid) begin
			check_true(1'b0, "step_valid never rose after the load.");
			return;
		end
		check_true(waited == 1, $sformatf("step_valid rose %0d cycles late.", waited - 1));
		for (int i = 0; i < steps; i++) begin
			x = alpha_pow(i);
			ev = locator_eval(coeffs, x);
			check_val("step_valid", {3'b0, step_valid}, 4'h1, i);
			check_val("position", position, 4'(i), i);
			check_val("eval_value", eval_value, ev, i);
			check_val("odd_value", odd_value, odd_terms(coeffs, x), i);
			check_val("root", {3'b0, root}, {3'b0, (ev == 4'h0)}, i);
			check_val("busy", {3'b0, busy}, 4'h1, i);
			if (root) begin
				seen_roots[i] = 1'b1;
			end
			if (ev == 4'h0) begin
				exp_count++;
			end
			if (i == N - 1) begin
				check_true(done, "done did not come with the last position.");
				check_val("root_count", root_count, 4'(exp_count), i);
			end else begin
				check_val("done", {3'b0, done}, 4'h0, i);
			end
			@(negedge clk);
		end
		if (steps == N) begin
			check_val("step_valid", {3'b0, step_valid}, 4'h0, N);
			check_val("done", {3'b0, done}, 4'h0, N);
			check_val("busy", {3'b0, busy}, 4'h0, N);
			check_val("root_count", root_count, 4'(exp_count), N);
		end
	endtask

	task automatic test_reset_state();
		int start;
		start = errors;
		for (int c = 0; c < 6; c++) begin
			check_val("step_valid", {3'b0, step_valid}, 4'h0, c);
			check_val("done", {3'b0, done}, 4'h0, c);
			check_val("root", {3'b0, root}, 4'h0, c);
			check_val("busy", {3'b0, busy}, 4'h0, c);
			check_val("root_count", root_count, 4'h0, c);
			@(negedge clk);
		end
		finish_test("reset state", start);
	endtask

	task automatic test_single_error();
		int start;
		logic [T:0][3:0] s;
		start = errors;
		for (int p = 0; p < N; p++) begin
			s = '0;
			s[0] = 4'h1;
			s[1] = alpha_pow(p);
			run_locator(s, N);
			check_roots(15'(1) << ((N - p) % N));
			check_val("root_count", root_count, 4'h1, N);
		end
		finish_test("single-error locators", start);
	endtask

	task automatic check_product(input int nf, input int p0, input int p1, input int p2);
		logic [T:0][3:0] s;
		logic [N-1:0] mask;
		int ps [3];
		ps = '{p0, p1, p2};
		s = '0;
		s[0] = 4'h1;
		mask = '0;
		for (int k = 0; k < nf; k++) begin
			s = mul_factor(s, ps[k]);
			mask[(N - ps[k]) % N] = 1'b1;
		end
		run_locator(s, N);
		check_roots(mask);
		check_val("root_count", root_count, 4'(nf), N);
	endtask

	task automatic test_multi_error();
		int start;
		start = errors;
		check_product(2, 2, 9, 0);
		check_product(2, 0, 7, 0);
		check_product(3, 1, 5, 12);
		check_product(3, 3, 8, 14);
		finish_test("multi-error locators", start);
	endtask

	task automatic test_random();
		int start;
		logic [T:0][3:0] s;
		start = errors;
		for (int r = 0; r < 20; r++) begin
			rng_state = xorshift32(rng_state);
			for (int j = 0; j <= T; j++) begin
				s[j] = rng_state[4*j +: 4];
			end
			run_locator(s, N);
		end
		finish_test("random coefficients", start);
	endtask

	// the count must hold while the unit sits idle after done.
	task automatic test_run_timing();
		int start;
		logic [T:0][3:0] s;
		start = errors;
		s = mul_factor(mul_factor({4'h0, 4'h0, 4'h0, 4'h1}, 4), 11);
		run_locator(s, N);
		for (int c = 0; c < 6; c++) begin
			check_val("step_valid", {3'b0, step_valid}, 4'h0, c);
			check_val("busy", {3'b0, busy}, 4'h0, c);
			check_val("root_count", root_count, 4'h2, c);
			@(negedge clk);
		end
		finish_test("run timing", start);
	endtask

	task automatic test_restart();
		int start;
		start = errors;
		run_locator(mul_factor({4'h0, 4'h0, 4'h0, 4'h1}, 14), 6);
		run_locator({4'h7, 4'h0, 4'hc, 4'h5}, N);
		finish_test("restart", start);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		load = 1'b0;
		sigma = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rng_state = 32'd17563;
		seen_roots = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		test_reset_state();
		test_single_error();
		test_multi_error();
		test_random();
		test_run_timing();
		test_restart();
		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/gf_pkg.sv
src/gf_const_mul.sv
src/chien_bank.sv
src/chien_combine.sv
src/chien_search.sv
test/chien_search_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and scans the log for the failure line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module chien_search_tb -f project.f -o chien_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/chien_sim > sim.log 2>&1 || { cat sim.log; echo "simulation did not finish"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
exit 0
